// ==== rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  result_src_t;
    typedef logic [1:0]  fwd_sel_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // alu operations
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLT    = 4'd5;
    localparam alu_op_t ALU_SLTU   = 4'd6;
    localparam alu_op_t ALU_SLL    = 4'd7;
    localparam alu_op_t ALU_SRL    = 4'd8;
    localparam alu_op_t ALU_SRA    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // writeback source
    localparam result_src_t RES_ALU = 2'd0;
    localparam result_src_t RES_MEM = 2'd1;
    localparam result_src_t RES_PC4 = 2'd2;
    localparam result_src_t RES_IMM = 2'd3;

    // operand forwarding
    localparam fwd_sel_t FWD_NONE = 2'd0;
    localparam fwd_sel_t FWD_M    = 2'd1;
    localparam fwd_sel_t FWD_W    = 2'd2;

    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    // branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;
    // lw and sw width
    localparam funct3_t F3_WORD = 3'b010;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR    = 32'h0000_0013;
    localparam word_t EBREAK_INSTR = 32'h0010_0073;

endpackage

// ==== fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          stall_d,
    input  logic          redirect,
    input  rv_pkg::word_t redirect_pc,
    input  logic          halt,
    output rv_pkg::word_t pc,
    output logic          imem_req
);

    logic halted;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= RESET_PC;
            halted <= 1'b0;
        end else begin
            if (halt) begin
                halted <= 1'b1;
            end
            // redirect wins over a plain advance
            if (redirect) begin
                pc <= redirect_pc;
            end else if (!stall_d && !halted && !halt) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // one request per cycle until ebreak
    assign imem_req = ~halted;

endmodule

// ==== instr_decoder.sv ====
`timescale 1ns/100ps

module instr_decoder (
    input  rv_pkg::word_t       instr,
    output rv_pkg::reg_addr_t   rs1,
    output rv_pkg::reg_addr_t   rs2,
    output rv_pkg::reg_addr_t   rd,
    output rv_pkg::word_t       imm,
    output rv_pkg::alu_op_t     alu_op,
    output logic                alu_src_imm,
    output logic                use_pc_a,
    output logic                reg_wen,
    output logic                mem_wen,
    output logic                mem_ren,
    output rv_pkg::result_src_t result_src,
    output logic                branch,
    output logic                jal,
    output logic                jalr,
    output rv_pkg::funct3_t     funct3,
    output logic                is_ebreak
);

    rv_pkg::opcode_t opcode;
    rv_pkg::alu_op_t arith_op;
    rv_pkg::word_t   imm_i;
    rv_pkg::word_t   imm_s;
    rv_pkg::word_t   imm_b;
    rv_pkg::word_t   imm_u;
    rv_pkg::word_t   imm_j;
    logic            alt;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    // bit 30 picks sub and sra
    assign alt    = instr[30];

    // ------------------------------------------------------------
    // immediate formats
    // ------------------------------------------------------------
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // shared funct3 map for OP and OP_IMM
    always_comb begin
        case (funct3)
            3'b001:  arith_op = rv_pkg::ALU_SLL;
            3'b010:  arith_op = rv_pkg::ALU_SLT;
            3'b011:  arith_op = rv_pkg::ALU_SLTU;
            3'b100:  arith_op = rv_pkg::ALU_XOR;
            3'b101:  arith_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  arith_op = rv_pkg::ALU_OR;
            3'b111:  arith_op = rv_pkg::ALU_AND;
            default: arith_op = rv_pkg::ALU_ADD;
        endcase
    end

    // ------------------------------------------------------------
    // control decode
    // ------------------------------------------------------------
    always_comb begin
        // defaults form a no-op
        imm         = imm_i;
        alu_op      = rv_pkg::ALU_ADD;
        alu_src_imm = 1'b0;
        use_pc_a    = 1'b0;
        reg_wen     = 1'b0;
        mem_wen     = 1'b0;
        mem_ren     = 1'b0;
        result_src  = rv_pkg::RES_ALU;
        branch      = 1'b0;
        jal         = 1'b0;
        jalr        = 1'b0;
        is_ebreak   = 1'b0;
        case (opcode)
            rv_pkg::OPC_OP: begin
                alu_op  = (funct3 == 3'b000 && alt) ? rv_pkg::ALU_SUB : arith_op;
                reg_wen = 1'b1;
            end
            rv_pkg::OPC_OP_IMM: begin
                alu_op      = arith_op;
                alu_src_imm = 1'b1;
                reg_wen     = 1'b1;
            end
            rv_pkg::OPC_LUI: begin
                imm         = imm_u;
                alu_op      = rv_pkg::ALU_PASS_B;
                alu_src_imm = 1'b1;
                result_src  = rv_pkg::RES_IMM;
                reg_wen     = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                imm         = imm_u;
                use_pc_a    = 1'b1;
                alu_src_imm = 1'b1;
                reg_wen     = 1'b1;
            end
            rv_pkg::OPC_LOAD: begin
                alu_src_imm = 1'b1;
                mem_ren     = (funct3 == rv_pkg::F3_WORD);
                reg_wen     = (funct3 == rv_pkg::F3_WORD);
                result_src  = rv_pkg::RES_MEM;
            end
            rv_pkg::OPC_STORE: begin
                imm         = imm_s;
                alu_src_imm = 1'b1;
                mem_wen     = (funct3 == rv_pkg::F3_WORD);
            end
            rv_pkg::OPC_BRANCH: begin
                imm    = imm_b;
                // 010 and 011 are not branches
                branch = (funct3[2:1] != 2'b01);
            end
            rv_pkg::OPC_JAL: begin
                imm        = imm_j;
                jal        = 1'b1;
                reg_wen    = 1'b1;
                result_src = rv_pkg::RES_PC4;
            end
            rv_pkg::OPC_JALR: begin
                jalr       = (funct3 == 3'b000);
                reg_wen    = (funct3 == 3'b000);
                result_src = rv_pkg::RES_PC4;
            end
            rv_pkg::OPC_SYSTEM: begin
                is_ebreak = (instr == rv_pkg::EBREAK_INSTR);
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== register_file.sv ====
`timescale 1ns/100ps

module register_file (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::reg_addr_t raddr1,
    input  rv_pkg::reg_addr_t raddr2,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::word_t     wdata,
    input  logic              wen
);

    rv_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads zero, a write in flight is seen at once
    function automatic rv_pkg::word_t read_port(rv_pkg::reg_addr_t addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (wen && addr == waddr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    assign rdata1 = read_port(raddr1);
    assign rdata2 = read_port(raddr2);

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/100ps

module hazard_unit (
    input  rv_pkg::reg_addr_t rs1_d,
    input  rv_pkg::reg_addr_t rs2_d,
    input  rv_pkg::reg_addr_t rs1_e,
    input  rv_pkg::reg_addr_t rs2_e,
    input  rv_pkg::reg_addr_t rd_e,
    input  rv_pkg::reg_addr_t rd_m,
    input  rv_pkg::reg_addr_t rd_w,
    input  logic              load_e,
    input  logic              wen_m,
    input  logic              wen_w,
    input  logic              valid_e,
    input  logic              valid_m,
    input  logic              valid_w,
    input  logic              taken_e,
    output logic              stall_d,
    output logic              flush,
    output rv_pkg::fwd_sel_t  fwd_a,
    output rv_pkg::fwd_sel_t  fwd_b
);

    logic live_m;
    logic live_w;

    // producers that will write a real register
    assign live_m = valid_m && wen_m && rd_m != 5'd0;
    assign live_w = valid_w && wen_w && rd_w != 5'd0;

    // load result is not ready until W
    assign stall_d = valid_e && load_e && rd_e != 5'd0 && (rd_e == rs1_d || rd_e == rs2_d);

    assign flush = valid_e && taken_e;

    // younger producer in M takes priority
    function automatic rv_pkg::fwd_sel_t pick(rv_pkg::reg_addr_t src);
        if (live_m && rd_m == src) begin
            return rv_pkg::FWD_M;
        end else if (live_w && rd_w == src) begin
            return rv_pkg::FWD_W;
        end
        return rv_pkg::FWD_NONE;
    endfunction

    assign fwd_a = pick(rs1_e);
    assign fwd_b = pick(rs2_e);

endmodule

// ==== execute_unit.sv ====
`timescale 1ns/100ps

module execute_unit (
    input  rv_pkg::word_t       pc_e,
    input  rv_pkg::word_t       rdata1_e,
    input  rv_pkg::word_t       rdata2_e,
    input  rv_pkg::word_t       imm_e,
    input  rv_pkg::word_t       fwd_m_value,
    input  rv_pkg::word_t       fwd_w_value,
    input  rv_pkg::fwd_sel_t    fwd_a,
    input  rv_pkg::fwd_sel_t    fwd_b,
    input  rv_pkg::alu_op_t     alu_op,
    input  logic                alu_src_imm,
    input  logic                use_pc_a,
    input  logic                branch,
    input  logic                jal,
    input  logic                jalr,
    input  logic                valid_e,
    input  rv_pkg::funct3_t     funct3,
    input  rv_pkg::result_src_t result_src,
    output rv_pkg::word_t       result_e,
    output rv_pkg::word_t       store_data_e,
    output rv_pkg::word_t       redirect_pc,
    output logic                taken
);

    rv_pkg::word_t src_a;
    rv_pkg::word_t src_b;
    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    rv_pkg::word_t alu_y;
    rv_pkg::word_t pc_plus4;
    logic          cond;

    function automatic rv_pkg::word_t fwd_mux(rv_pkg::fwd_sel_t sel, rv_pkg::word_t reg_val);
        case (sel)
            rv_pkg::FWD_M: return fwd_m_value;
            rv_pkg::FWD_W: return fwd_w_value;
            default:       return reg_val;
        endcase
    endfunction

    assign src_a = fwd_mux(fwd_a, rdata1_e);
    assign src_b = fwd_mux(fwd_b, rdata2_e);
    assign op_a  = use_pc_a ? pc_e : src_a;
    assign op_b  = alu_src_imm ? imm_e : src_b;

    // ------------------------------------------------------------
    // alu
    // ------------------------------------------------------------
    always_comb begin
        case (alu_op)
            rv_pkg::ALU_SUB:    alu_y = op_a - op_b;
            rv_pkg::ALU_AND:    alu_y = op_a & op_b;
            rv_pkg::ALU_OR:     alu_y = op_a | op_b;
            rv_pkg::ALU_XOR:    alu_y = op_a ^ op_b;
            rv_pkg::ALU_SLT:    alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU:   alu_y = {31'b0, op_a < op_b};
            rv_pkg::ALU_SLL:    alu_y = op_a << op_b[4:0];
            rv_pkg::ALU_SRL:    alu_y = op_a >> op_b[4:0];
            rv_pkg::ALU_SRA:    alu_y = $unsigned($signed(op_a) >>> op_b[4:0]);
            rv_pkg::ALU_PASS_B: alu_y = op_b;
            default:            alu_y = op_a + op_b;
        endcase
    end

    // branch compare on the forwarded register values
    always_comb begin
        case (funct3)
            rv_pkg::F3_BEQ:  cond = (src_a == src_b);
            rv_pkg::F3_BNE:  cond = (src_a != src_b);
            rv_pkg::F3_BLT:  cond = ($signed(src_a) < $signed(src_b));
            rv_pkg::F3_BGE:  cond = ($signed(src_a) >= $signed(src_b));
            rv_pkg::F3_BLTU: cond = (src_a < src_b);
            rv_pkg::F3_BGEU: cond = (src_a >= src_b);
            default:         cond = 1'b0;
        endcase
    end

    assign pc_plus4 = pc_e + 32'd4;

    always_comb begin
        case (result_src)
            rv_pkg::RES_PC4: result_e = pc_plus4;
            rv_pkg::RES_IMM: result_e = imm_e;
            default:         result_e = alu_y;
        endcase
    end

    assign store_data_e = src_b;
    assign taken        = valid_e && (jal || jalr || (branch && cond));
    // jalr target has bit 0 cleared
    assign redirect_pc  = jalr ? ((src_a + imm_e) & ~32'd1) : (pc_e + imm_e);

endmodule

// ==== rv_pipeline.sv ====
`timescale 1ns/100ps

module rv_pipeline #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          rst,
    output rv_pkg::word_t imem_addr,
    output logic          imem_req,
    input  rv_pkg::word_t imem_rdata,
    output rv_pkg::word_t dmem_addr,
    output rv_pkg::word_t dmem_wdata,
    output logic          dmem_wen,
    output logic          dmem_ren,
    input  rv_pkg::word_t dmem_rdata,
    output rv_pkg::word_t pc_w,
    output logic          valid_w,
    output logic          ebreak
);

    // hazard and redirect
    logic                stall_d, flush, taken, halt;
    rv_pkg::fwd_sel_t    fwd_a, fwd_b;
    rv_pkg::word_t       redirect_pc, pc_f;

    // decode stage
    logic                valid_d, hold_d;
    rv_pkg::word_t       pc_d, instr_d, instr_hold, imm_d, rdata1_d, rdata2_d;
    rv_pkg::reg_addr_t   rs1_d, rs2_d, rd_d;
    rv_pkg::alu_op_t     alu_op_d;
    rv_pkg::result_src_t result_src_d;
    rv_pkg::funct3_t     funct3_d;
    logic                alu_src_imm_d, use_pc_a_d, reg_wen_d, mem_wen_d, mem_ren_d;
    logic                branch_d, jal_d, jalr_d, ebreak_d;

    // execute stage
    logic                valid_e;
    rv_pkg::word_t       pc_e, imm_e, rdata1_e, rdata2_e, result_e, store_data_e;
    rv_pkg::reg_addr_t   rs1_e, rs2_e, rd_e;
    rv_pkg::alu_op_t     alu_op_e;
    rv_pkg::result_src_t result_src_e;
    rv_pkg::funct3_t     funct3_e;
    logic                alu_src_imm_e, use_pc_a_e, reg_wen_e, mem_wen_e, mem_ren_e;
    logic                branch_e, jal_e, jalr_e, ebreak_e;

    // memory and writeback stages
    logic                valid_m, reg_wen_m, mem_wen_m, mem_ren_m, ebreak_m, reg_wen_w;
    rv_pkg::word_t       pc_m, result_m, store_data_m, result_w, wb_value;
    rv_pkg::reg_addr_t   rd_m, rd_w;
    rv_pkg::result_src_t result_src_m, result_src_w;

    // ebreak in execute stops fetch and kills everything younger
    assign halt = valid_e && ebreak_e;

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .rst(rst), .stall_d(stall_d), .redirect(taken),
        .redirect_pc(redirect_pc), .halt(halt), .pc(pc_f), .imem_req(imem_req)
    );

    assign imem_addr = pc_f;

    // ------------------------------------------------------------
    // decode buffer
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_d <= 1'b0;
            hold_d  <= 1'b0;
        end else if (stall_d) begin
            hold_d <= 1'b1;
        end else begin
            valid_d <= imem_req;
            hold_d  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (stall_d) begin
            instr_hold <= instr_d;
        end else begin
            pc_d <= pc_f;
        end
    end

    // memory has moved on during a stall so replay the held word
    assign instr_d = !valid_d ? rv_pkg::NOP_INSTR : (hold_d ? instr_hold : imem_rdata);

    instr_decoder u_decoder (
        .instr(instr_d), .rs1(rs1_d), .rs2(rs2_d), .rd(rd_d), .imm(imm_d),
        .alu_op(alu_op_d), .alu_src_imm(alu_src_imm_d), .use_pc_a(use_pc_a_d),
        .reg_wen(reg_wen_d), .mem_wen(mem_wen_d), .mem_ren(mem_ren_d),
        .result_src(result_src_d), .branch(branch_d), .jal(jal_d), .jalr(jalr_d),
        .funct3(funct3_d), .is_ebreak(ebreak_d)
    );

    register_file u_regs (
        .clk(clk), .rst(rst), .raddr1(rs1_d), .raddr2(rs2_d),
        .rdata1(rdata1_d), .rdata2(rdata2_d),
        .waddr(rd_w), .wdata(wb_value), .wen(valid_w && reg_wen_w)
    );

    hazard_unit u_hazard (
        .rs1_d(rs1_d), .rs2_d(rs2_d), .rs1_e(rs1_e), .rs2_e(rs2_e),
        .rd_e(rd_e), .rd_m(rd_m), .rd_w(rd_w), .load_e(mem_ren_e),
        .wen_m(reg_wen_m), .wen_w(reg_wen_w),
        .valid_e(valid_e), .valid_m(valid_m), .valid_w(valid_w),
        .taken_e(taken || ebreak_e), .stall_d(stall_d), .flush(flush),
        .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    // ------------------------------------------------------------
    // execute buffer
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst || flush || stall_d) begin
            valid_e <= 1'b0;
        end else begin
            valid_e <= valid_d;
        end
    end

    always_ff @(posedge clk) begin
        pc_e          <= pc_d;
        imm_e         <= imm_d;
        rdata1_e      <= rdata1_d;
        rdata2_e      <= rdata2_d;
        rs1_e         <= rs1_d;
        rs2_e         <= rs2_d;
        rd_e          <= rd_d;
        alu_op_e      <= alu_op_d;
        result_src_e  <= result_src_d;
        funct3_e      <= funct3_d;
        alu_src_imm_e <= alu_src_imm_d;
        use_pc_a_e    <= use_pc_a_d;
        reg_wen_e     <= reg_wen_d;
        mem_wen_e     <= mem_wen_d;
        mem_ren_e     <= mem_ren_d;
        branch_e      <= branch_d;
        jal_e         <= jal_d;
        jalr_e        <= jalr_d;
        ebreak_e      <= ebreak_d;
    end

    execute_unit u_execute (
        .pc_e(pc_e), .rdata1_e(rdata1_e), .rdata2_e(rdata2_e), .imm_e(imm_e),
        .fwd_m_value(result_m), .fwd_w_value(wb_value), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .alu_op(alu_op_e), .alu_src_imm(alu_src_imm_e), .use_pc_a(use_pc_a_e),
        .branch(branch_e), .jal(jal_e), .jalr(jalr_e), .valid_e(valid_e),
        .funct3(funct3_e), .result_src(result_src_e), .result_e(result_e),
        .store_data_e(store_data_e), .redirect_pc(redirect_pc), .taken(taken)
    );

    // ------------------------------------------------------------
    // memory and writeback buffers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_m <= 1'b0;
            valid_w <= 1'b0;
            ebreak  <= 1'b0;
        end else begin
            valid_m <= valid_e;
            valid_w <= valid_m;
            // rises as the ebreak enters W and sticks
            ebreak  <= ebreak || (valid_m && ebreak_m);
        end
    end

    always_ff @(posedge clk) begin
        pc_m         <= pc_e;
        rd_m         <= rd_e;
        result_m     <= result_e;
        store_data_m <= store_data_e;
        result_src_m <= result_src_e;
        reg_wen_m    <= reg_wen_e;
        mem_wen_m    <= mem_wen_e;
        mem_ren_m    <= mem_ren_e;
        ebreak_m     <= ebreak_e;
        pc_w         <= pc_m;
        rd_w         <= rd_m;
        result_w     <= result_m;
        result_src_w <= result_src_m;
        reg_wen_w    <= reg_wen_m;
    end

    assign dmem_addr  = result_m;
    assign dmem_wdata = store_data_m;
    assign dmem_wen   = valid_m && mem_wen_m;
    assign dmem_ren   = valid_m && mem_ren_m;

    // load data arrives one cycle after the M-stage read
    assign wb_value = (result_src_w == rv_pkg::RES_MEM) ? dmem_rdata : result_w;

endmodule

// ==== rv_pipeline_tb.sv ====
`timescale 1ns/100ps

module rv_pipeline_tb;

    localparam int MEM_WORDS = 1024;
    localparam int MAX_TESTS = 8;

    logic          clk;
    logic          rst;
    rv_pkg::word_t imem_addr;
    logic          imem_req;
    rv_pkg::word_t imem_rdata;
    rv_pkg::word_t dmem_addr;
    rv_pkg::word_t dmem_wdata;
    logic          dmem_wen;
    logic          dmem_ren;
    rv_pkg::word_t dmem_rdata;
    rv_pkg::word_t pc_w;
    logic          valid_w;
    logic          ebreak;

    rv_pipeline #(.RESET_PC(32'h0)) UUT (
        .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_req(imem_req),
        .imem_rdata(imem_rdata), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_wen(dmem_wen), .dmem_ren(dmem_ren), .dmem_rdata(dmem_rdata),
        .pc_w(pc_w), .valid_w(valid_w), .ebreak(ebreak)
    );

    // shared instruction and data memory
    rv_pkg::word_t mem [0:MEM_WORDS-1];
    logic          cap_ireq, cap_wen, cap_ren;
    rv_pkg::word_t cap_iaddr, cap_daddr, cap_wdata;

    // test table read from the data file
    string         test_name [MAX_TESTS];
    int            prog_first [MAX_TESTS];
    int            prog_count [MAX_TESTS];
    int            store_first [MAX_TESTS];
    int            store_count [MAX_TESTS];
    rv_pkg::word_t halt_pc [MAX_TESTS];
    rv_pkg::word_t prog_words [$];
    rv_pkg::word_t store_addr [$];
    rv_pkg::word_t store_data [$];
    int            num_tests;
    int            total_words;
    int            cycle_limit;
    int            cycles;
    string         current_name;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // memory model with one cycle read latency on both ports
    // ------------------------------------------------------------
    always @(negedge clk) begin
        cap_ireq  = imem_req;
        cap_iaddr = imem_addr;
        cap_wen   = dmem_wen;
        cap_ren   = dmem_ren;
        cap_daddr = dmem_addr;
        cap_wdata = dmem_wdata;
    end

    always @(posedge clk) begin
        #1;
        if (cap_wen === 1'b1) begin
            mem[cap_daddr[11:2]] = cap_wdata;
        end
        if (cap_ireq === 1'b1) begin
            imem_rdata = mem[cap_iaddr[11:2]];
        end
        if (cap_ren === 1'b1) begin
            dmem_rdata = mem[cap_daddr[11:2]];
        end
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: test %s, %s: expected %h, actual %h",
                     current_name, what, expected, actual);
            stop_with_failure("a DUT output did not match");
        end
    endtask

    task automatic count_cycle();
        cycles++;
        if (cycles > cycle_limit) begin
            stop_with_failure("timeout: the DUT did not halt within the cycle limit");
        end
    endtask

    // ------------------------------------------------------------
    // test file reader
    // ------------------------------------------------------------
    task automatic load_tests();
        int            fd;
        int            code;
        int            n;
        string         tok;
        string         line;
        rv_pkg::word_t w;
        rv_pkg::word_t d;
        fd = $fopen("core_tests.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open core_tests.txt");
        end
        num_tests   = 0;
        total_words = 0;
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                break;
            end
            if (tok.getc(0) == 8'h23) begin
                code = $fgets(line, fd);
            end else if (tok == "test") begin
                code = $fscanf(fd, "%s", test_name[num_tests]);
                num_tests++;
            end else if (tok == "prog") begin
                code = $fscanf(fd, "%d", n);
                prog_first[num_tests-1] = prog_words.size();
                prog_count[num_tests-1] = n;
                total_words += n;
                for (int i = 0; i < n; i++) begin
                    code = $fscanf(fd, "%h", w);
                    prog_words.push_back(w);
                end
            end else if (tok == "store") begin
                code = $fscanf(fd, "%d", n);
                store_first[num_tests-1] = store_addr.size();
                store_count[num_tests-1] = n;
                for (int i = 0; i < n; i++) begin
                    code = $fscanf(fd, "%h %h", w, d);
                    store_addr.push_back(w);
                    store_data.push_back(d);
                end
            end else if (tok == "halt") begin
                code = $fscanf(fd, "%h", halt_pc[num_tests-1]);
            end else begin
                stop_with_failure("unknown keyword in core_tests.txt");
            end
        end
        $fclose(fd);
    endtask

    task automatic fill_memory(input int t);
        rv_pkg::word_t addr;
        for (int i = 0; i < MEM_WORDS; i++) begin
            addr   = i * 4;
            mem[i] = {~addr[15:0], addr[15:0]};
        end
        for (int i = 0; i < prog_count[t]; i++) begin
            mem[i] = prog_words[prog_first[t] + i];
        end
    endtask

    task automatic run_test(input int t);
        int next_store;
        current_name = test_name[t];
        next_store   = store_first[t];
        @(posedge clk);
        #1 rst = 1'b1;
        fill_memory(t);
        // outputs stay quiet while reset is held
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            #1;
            if (k == 3) begin
                rst = 1'b0;
            end
            #1;
            check_value("valid_w in reset", 32'd0, 32'(valid_w));
            check_value("ebreak in reset", 32'd0, 32'(ebreak));
            check_value("dmem_wen in reset", 32'd0, 32'(dmem_wen));
            check_value("dmem_ren in reset", 32'd0, 32'(dmem_ren));
            count_cycle();
        end
        @(negedge clk);
        check_value("first imem_req", 32'd1, 32'(imem_req));
        check_value("first imem_addr", 32'h0, imem_addr);
        forever begin
            @(negedge clk);
            count_cycle();
            if (dmem_wen === 1'b1) begin
                if (next_store >= store_first[t] + store_count[t]) begin
                    stop_with_failure("a store appeared that the test does not expect");
                end
                check_value("store address", store_addr[next_store], dmem_addr);
                check_value("store data", store_data[next_store], dmem_wdata);
                next_store++;
            end
            // ebreak must rise in the same cycle that it retires
            if (ebreak === 1'b1) begin
                check_value("valid_w with ebreak", 32'd1, 32'(valid_w));
                break;
            end
        end
        check_value("halt pc", halt_pc[t], pc_w);
        check_value("stores seen", store_first[t] + store_count[t], next_store);
        // nothing retires or stores once halted
        repeat (20) begin
            @(negedge clk);
            count_cycle();
            check_value("valid_w after halt", 32'd0, 32'(valid_w));
            check_value("dmem_wen after halt", 32'd0, 32'(dmem_wen));
            check_value("dmem_ren after halt", 32'd0, 32'(dmem_ren));
            check_value("imem_req after halt", 32'd0, 32'(imem_req));
            check_value("ebreak after halt", 32'd1, 32'(ebreak));
        end
    endtask

    initial begin
        rst        = 1'b1;
        imem_rdata = '0;
        dmem_rdata = '0;
        cycles     = 0;
        load_tests();
        cycle_limit = 8 * total_words + 50 * num_tests;
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== core_tests.txt ====
# test <name>, prog <count> <hex words from address 0>
# store <count> <hex address> <hex data> ..., halt <hex pc of ebreak>
test alu_imm
prog 27
01900093 FF900113 002081B3 40208233 0020F2B3 0020E333
0020C3B3 00112433 001134B3 00111533 00415593 40415613
123456B7 00001717 10302023 10402223 10502423 10602623
10702823 10802A23 10902C23 10A02E23 12B02023 12C02223
12D02423 12E02623 00100073
store 12
100 00000012 104 00000020 108 00000019 10C FFFFFFF9
110 FFFFFFE0 114 00000001 118 00000000 11C F2000000
120 0FFFFFFF 124 FFFFFFFF 128 12345000 12C 00001034
halt 68
test forwarding
prog 9
00500093 00308113 00100193 00110233 403202B3 10502023
10402223 10202423 00100073
store 3
100 0000000C 104 0000000D 108 00000008
halt 20
test load_use
prog 8
06400093 10102023 10002103 001101B3 10302223 10402203
10402423 00100073
store 3
100 00000064 104 000000C8 108 000000C8
halt 1C
test control_flow
prog 35
00100093 FFF00113 00108463 1E202823 00208463 10102023
00209463 1E202823 00109463 10102223 00114463 1E202823
0020C463 10102423 0020D463 1E202823 00115463 10102623
0020E463 1E202823 00116463 10102823 00117463 1E202823
0020F463 10102A23 008002EF 1E202823 10502C23 08400313
000303E7 1E202823 1E202823 10702E23 00100073
store 8
100 00000001 104 00000001 108 00000001 10C 00000001
110 00000001 114 00000001 118 0000006C 11C 0000007C
halt 88

// ==== tb.f ====
rv_pkg.sv
fetch_unit.sv
instr_decoder.sv
register_file.sv
hazard_unit.sv
execute_unit.sv
rv_pipeline.sv
rv_pipeline_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the rv_pipeline testbench with Verilator.
# The exit status is the simulator's own: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module rv_pipeline_tb -f tb.f -o rv_pipeline_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/rv_pipeline_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation failed with status $sim_status"
fi
exit $sim_status
